//--- vseq_cfg_pkg.sv
// Sequencer configuration with sizes, execution unit codes and default queue depths
package vseq_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction IDs
  //////////////////////////////////////////////////////////////////////

  // Instructions that may be in flight at once
  localparam int unsigned NR_VINSN = 8;
  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  // One bit per instruction ID, used as one-hot or as a mask
  typedef logic [NR_VINSN-1:0] vid_vec_t;

  //////////////////////////////////////////////////////////////////////
  // Vector registers and execution units
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NR_VREGS = 32;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;

  localparam int unsigned NR_UNITS = 4;
  // Encoding doubles as the index into per-unit vectors
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  // Credit counter width, enough for the deepest queue
  localparam int unsigned CNT_W = 3;

  // Default queue slots per unit
  localparam int unsigned DEF_ALU_DEPTH   = 2;
  localparam int unsigned DEF_MUL_DEPTH   = 2;
  localparam int unsigned DEF_LOAD_DEPTH  = 4;
  localparam int unsigned DEF_STORE_DEPTH = 4;

endpackage

//--- vseq_req_pkg.sv
// Request, issue, completion and response types exchanged by the vector sequencer
package vseq_req_pkg;

  import vseq_cfg_pkg::*;

  // Opcodes known to the sequencer
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_MUL   = 3'd1,
    OP_LOAD  = 3'd2,
    OP_STORE = 3'd3,
    OP_MVXS  = 3'd4
  } op_e;

  // Decoded instruction from the dispatcher
  typedef struct packed {
    op_e         op;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic        use_vd;
    logic        use_vs1;
    logic        use_vs2;
    logic [15:0] vl;
  } seq_req_t;

  // Issued request, carrying ID, target unit and chaining hazards
  typedef struct packed {
    seq_req_t req;
    vid_t     id;
    unit_e    unit;
    vid_vec_t hazard_vd;
    vid_vec_t hazard_vs1;
    vid_vec_t hazard_vs2;
  } pe_req_t;

  // Completion report, at most one per unit and cycle
  typedef struct packed {
    logic valid;
    vid_t vid;
  } unit_done_t;

  // Store answer, padded up to a full word
  typedef struct packed {
    logic [14:0] pad;
    logic        fault;
    logic [15:0] fault_vstart;
  } store_status_t;

  // Unit answer word, meaning depends on the op it answers
  typedef union packed {
    logic [31:0]   scalar_data;
    store_status_t store_status;
  } resp_word_u;

  // Answer back to the dispatcher
  typedef struct packed {
    op_e        op;
    resp_word_u word;
  } seq_resp_t;

endpackage

//--- vinsn_tracker.sv
// Running-instruction bitmap with lowest free ID search and idle flag
`timescale 1ns/100ps

module vinsn_tracker (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 issue_i,
  input  vseq_cfg_pkg::vid_t                                   issue_vid_i,
  input  vseq_req_pkg::unit_done_t [vseq_cfg_pkg::NR_UNITS-1:0] unit_done_i,
  output vseq_cfg_pkg::vid_vec_t                               running_d_o,
  output vseq_cfg_pkg::vid_t                                   next_vid_o,
  output logic                                                 id_full_o,
  output logic                                                 idle_o
);

  import vseq_cfg_pkg::*;

  // Bit set while the instruction with that ID is in flight
  vid_vec_t running_q;
  // IDs finishing this cycle
  vid_vec_t done_vec;
  // One-hot of the ID being handed out
  vid_vec_t issue_vec;

  // Collect completions from all units
  always_comb begin : p_done
    done_vec = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_done_i[u].valid) begin
        done_vec[unit_done_i[u].vid] = 1'b1;
      end
    end
  end

  assign issue_vec = issue_i ? (vid_vec_t'(1) << issue_vid_i) : '0;

  // Completions applied, new issue left out so hazards stay loop free
  assign running_d_o = running_q & ~done_vec;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_running_ff
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d_o | issue_vec;
    end
  end

  // Trailing-zero count over the free vector, lowest free ID wins
  always_comb begin : p_next_id
    next_vid_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_vid_o = vid_t'(i);
      end
    end
  end

  assign id_full_o = &running_q;
  assign idle_o    = ~|running_q;

endmodule

//--- vreg_access_lists.sv
// Per-register last reader and writer lists with RAW, WAR and WAW hazard vectors
`timescale 1ns/100ps

module vreg_access_lists (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  vseq_req_pkg::seq_req_t req_i,
  input  vseq_cfg_pkg::vid_vec_t running_d_i,
  input  logic                   issue_i,
  input  vseq_cfg_pkg::vid_t     issue_vid_i,
  output vseq_cfg_pkg::vid_vec_t hazard_vd_o,
  output vseq_cfg_pkg::vid_vec_t hazard_vs1_o,
  output vseq_cfg_pkg::vid_vec_t hazard_vs2_o
);

  import vseq_cfg_pkg::*;

  // Last access to a register
  typedef struct packed {
    logic valid;
    vid_t vid;
  } vreg_access_t;

  // Registered lists
  vreg_access_t [NR_VREGS-1:0] rd_list_q;
  vreg_access_t [NR_VREGS-1:0] wr_list_q;
  // Lists with finished instructions dropped
  vreg_access_t [NR_VREGS-1:0] rd_list_d;
  vreg_access_t [NR_VREGS-1:0] wr_list_d;
  // Lists after recording the issued instruction
  vreg_access_t [NR_VREGS-1:0] rd_list_n;
  vreg_access_t [NR_VREGS-1:0] wr_list_n;

  // An entry stays valid only while its instruction runs
  always_comb begin : p_expire
    rd_list_d = rd_list_q;
    wr_list_d = wr_list_q;
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_list_d[v].valid = rd_list_q[v].valid & running_d_i[rd_list_q[v].vid];
      wr_list_d[v].valid = wr_list_q[v].valid & running_d_i[wr_list_q[v].vid];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Hazards of the incoming request
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_hazard
    hazard_vd_o  = '0;
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    // RAW on each source operand
    if (req_i.use_vs1 && wr_list_d[req_i.vs1].valid) begin
      hazard_vs1_o[wr_list_d[req_i.vs1].vid] = 1'b1;
    end
    if (req_i.use_vs2 && wr_list_d[req_i.vs2].valid) begin
      hazard_vs2_o[wr_list_d[req_i.vs2].vid] = 1'b1;
    end
    if (req_i.use_vd) begin
      // WAR, the destination must not overtake its last reader
      if (rd_list_d[req_i.vd].valid) begin
        hazard_vs1_o[rd_list_d[req_i.vd].vid] = 1'b1;
        hazard_vs2_o[rd_list_d[req_i.vd].vid] = 1'b1;
      end
      // WAW
      if (wr_list_d[req_i.vd].valid) begin
        hazard_vd_o[wr_list_d[req_i.vd].vid] = 1'b1;
      end
    end
  end

  // Record the issued instruction as newest reader and writer
  always_comb begin : p_record
    rd_list_n = rd_list_d;
    wr_list_n = wr_list_d;
    if (issue_i) begin
      if (req_i.use_vd) begin
        wr_list_n[req_i.vd] = '{valid: 1'b1, vid: issue_vid_i};
      end
      if (req_i.use_vs1) begin
        rd_list_n[req_i.vs1] = '{valid: 1'b1, vid: issue_vid_i};
      end
      if (req_i.use_vs2) begin
        rd_list_n[req_i.vs2] = '{valid: 1'b1, vid: issue_vid_i};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lists_ff
    if (!rst_ni) begin
      rd_list_q <= '0;
      wr_list_q <= '0;
    end else begin
      rd_list_q <= rd_list_n;
      wr_list_q <= wr_list_n;
    end
  end

endmodule

//--- hazard_table.sv
// Global hazard table, one producer row per running instruction
`timescale 1ns/100ps

module hazard_table (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                issue_i,
  input  vseq_cfg_pkg::vid_t                                  issue_vid_i,
  input  vseq_cfg_pkg::vid_vec_t                              hazard_vec_i,
  input  vseq_cfg_pkg::vid_vec_t                              running_d_i,
  output vseq_cfg_pkg::vid_vec_t [vseq_cfg_pkg::NR_VINSN-1:0] hazard_table_o
);

  import vseq_cfg_pkg::*;

  // Row N lists the instructions that N still depends on
  vid_vec_t [NR_VINSN-1:0] table_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_table_ff
    if (!rst_ni) begin
      table_q <= '0;
    end else begin
      // Finished producers drop out of every row
      for (int i = 0; i < NR_VINSN; i++) begin
        table_q[i] <= table_q[i] & running_d_i;
      end
      // New row overrides the masking, its ID was free before
      if (issue_i) begin
        table_q[issue_vid_i] <= hazard_vec_i;
      end
    end
  end

  assign hazard_table_o = table_q;

endmodule

//--- unit_credits.sv
// Per-unit credit counters gating issue to the execution unit queues
`timescale 1ns/100ps

module unit_credits #(
  parameter int unsigned ALU_DEPTH   = vseq_cfg_pkg::DEF_ALU_DEPTH,
  parameter int unsigned MUL_DEPTH   = vseq_cfg_pkg::DEF_MUL_DEPTH,
  parameter int unsigned LOAD_DEPTH  = vseq_cfg_pkg::DEF_LOAD_DEPTH,
  parameter int unsigned STORE_DEPTH = vseq_cfg_pkg::DEF_STORE_DEPTH
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 issue_i,
  input  vseq_cfg_pkg::unit_e                                  issue_unit_i,
  input  vseq_req_pkg::unit_done_t [vseq_cfg_pkg::NR_UNITS-1:0] unit_done_i,
  output logic [vseq_cfg_pkg::NR_UNITS-1:0]                    unit_credit_ok_o
);

  import vseq_cfg_pkg::*;

  // Queue slots, indexed by unit code
  localparam int unsigned DEPTH [NR_UNITS] = '{ALU_DEPTH, MUL_DEPTH, LOAD_DEPTH, STORE_DEPTH};

  for (genvar u = 0; u < NR_UNITS; u++) begin : gen_cnt
    // Outstanding instructions in this unit
    logic [CNT_W-1:0] cnt_q;
    logic             cnt_up;
    logic             cnt_dn;

    // Spend on issue, return on completion
    assign cnt_up = issue_i && (issue_unit_i == unit_e'(u));
    assign cnt_dn = unit_done_i[u].valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt_ff
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_dn) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!cnt_up && cnt_dn) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // A free slot is left
    assign unit_credit_ok_o[u] = cnt_q < CNT_W'(DEPTH[u]);
  end

endmodule

//--- issue_ctrl.sv
// Issue FSM with acceptance check, issue register and dispatcher response
`timescale 1ns/100ps

module issue_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Dispatcher request
  input  vseq_req_pkg::seq_req_t              req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  // Bookkeeping state
  input  vseq_cfg_pkg::vid_t                  next_vid_i,
  input  logic                                id_full_i,
  input  logic [vseq_cfg_pkg::NR_UNITS-1:0]   unit_credit_ok_i,
  input  vseq_cfg_pkg::vid_vec_t              hazard_vd_i,
  input  vseq_cfg_pkg::vid_vec_t              hazard_vs1_i,
  input  vseq_cfg_pkg::vid_vec_t              hazard_vs2_i,
  // Issue strobe towards the bookkeeping blocks
  output logic                                issue_o,
  output vseq_cfg_pkg::vid_t                  issue_vid_o,
  output vseq_cfg_pkg::unit_e                 issue_unit_o,
  // Issue to the units
  output vseq_req_pkg::pe_req_t               pe_req_o,
  output logic                                pe_req_valid_o,
  // Unit answer and dispatcher response
  input  vseq_req_pkg::resp_word_u            unit_resp_i,
  input  logic                                unit_resp_valid_i,
  output logic                                unit_resp_ready_o,
  output vseq_req_pkg::seq_resp_t             resp_o,
  output logic                                resp_valid_o
);

  import vseq_cfg_pkg::*;
  import vseq_req_pkg::*;

  // WAIT holds off new requests until the unit answers
  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e state_q;
  state_e state_d;
  unit_e  unit;
  logic   blocked;
  logic   needs_resp;
  logic   accept;

  // Scalar moves go through the ALU
  function automatic unit_e unit_of(op_e op);
    case (op)
      OP_MUL:   unit_of = UNIT_MUL;
      OP_LOAD:  unit_of = UNIT_LOAD;
      OP_STORE: unit_of = UNIT_STORE;
      default:  unit_of = UNIT_ALU;
    endcase
  endfunction

  assign unit = unit_of(req_i.op);

  // Operand readers chain, only operand-less ones must wait for clean hazards
  assign blocked = !(req_i.use_vs1 || req_i.use_vs2) &&
                   |{hazard_vd_i, hazard_vs1_i, hazard_vs2_i};

  // Ops that write no vector register report back to the dispatcher
  assign needs_resp = (req_i.op == OP_STORE) || (req_i.op == OP_MVXS);

  //////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d           = state_q;
    req_ready_o       = 1'b0;
    unit_resp_ready_o = 1'b0;
    resp_valid_o      = 1'b0;
    // Issue register still holds the op being waited on
    resp_o.op         = pe_req_o.req.op;
    resp_o.word       = unit_resp_i;
    case (state_q)
      IDLE: begin
        req_ready_o = !id_full_i && unit_credit_ok_i[unit] && !blocked;
        if (req_valid_i && req_ready_o && needs_resp) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (unit_resp_valid_i) begin
          unit_resp_ready_o = 1'b1;
          resp_valid_o      = 1'b1;
          state_d           = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign accept       = req_valid_i && req_ready_o;
  assign issue_o      = accept;
  assign issue_vid_o  = next_vid_i;
  assign issue_unit_o = unit;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      // One-cycle issue pulse, the unit holds a slot for it
      pe_req_valid_o <= accept;
    end
  end

  // Issued request with its ID, unit and chaining hazards
  always_ff @(posedge clk_i) begin : p_issue_ff
    if (accept) begin
      pe_req_o <= '{
        req:        req_i,
        id:         next_vid_i,
        unit:       unit,
        hazard_vd:  hazard_vd_i,
        hazard_vs1: hazard_vs1_i,
        hazard_vs2: hazard_vs2_i
      };
    end
  end

endmodule

//--- vseq_top.sv
// Vector sequencer top level joining ID tracker, access lists, hazard table, credits and issue FSM
`timescale 1ns/100ps

module vseq_top #(
  parameter int unsigned ALU_DEPTH   = vseq_cfg_pkg::DEF_ALU_DEPTH,
  parameter int unsigned MUL_DEPTH   = vseq_cfg_pkg::DEF_MUL_DEPTH,
  parameter int unsigned LOAD_DEPTH  = vseq_cfg_pkg::DEF_LOAD_DEPTH,
  parameter int unsigned STORE_DEPTH = vseq_cfg_pkg::DEF_STORE_DEPTH
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // Dispatcher request
  input  vseq_req_pkg::seq_req_t                               req_i,
  input  logic                                                 req_valid_i,
  output logic                                                 req_ready_o,
  // Issue to the execution units
  output vseq_req_pkg::pe_req_t                                pe_req_o,
  output logic                                                 pe_req_valid_o,
  input  vseq_req_pkg::unit_done_t [vseq_cfg_pkg::NR_UNITS-1:0] unit_done_i,
  // Store and scalar answers from the units
  input  vseq_req_pkg::resp_word_u                             unit_resp_i,
  input  logic                                                 unit_resp_valid_i,
  output logic                                                 unit_resp_ready_o,
  // Dispatcher response
  output vseq_req_pkg::seq_resp_t                              resp_o,
  output logic                                                 resp_valid_o,
  // Producer rows for operand fetch
  output vseq_cfg_pkg::vid_vec_t [vseq_cfg_pkg::NR_VINSN-1:0]  hazard_table_o,
  output logic                                                 idle_o
);

  import vseq_cfg_pkg::*;

  // Running set after this cycle's completions
  vid_vec_t              running_d;
  vid_t                  next_vid;
  logic                  id_full;
  // Hazards of the request at the dispatcher port
  vid_vec_t              hazard_vd;
  vid_vec_t              hazard_vs1;
  vid_vec_t              hazard_vs2;
  logic [NR_UNITS-1:0]   unit_credit_ok;
  // Issue strobe, shared by the bookkeeping blocks
  logic                  issue;
  vid_t                  issue_vid;
  unit_e                 issue_unit;

  vinsn_tracker u_vinsn_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .issue_vid_i (issue_vid),
    .unit_done_i (unit_done_i),
    .running_d_o (running_d),
    .next_vid_o  (next_vid),
    .id_full_o   (id_full),
    .idle_o      (idle_o)
  );

  vreg_access_lists u_vreg_access_lists (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .running_d_i  (running_d),
    .issue_i      (issue),
    .issue_vid_i  (issue_vid),
    .hazard_vd_o  (hazard_vd),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2)
  );

  // Table row holds every producer the instruction waits on
  hazard_table u_hazard_table (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue),
    .issue_vid_i    (issue_vid),
    .hazard_vec_i   (hazard_vd | hazard_vs1 | hazard_vs2),
    .running_d_i    (running_d),
    .hazard_table_o (hazard_table_o)
  );

  unit_credits #(
    .ALU_DEPTH   (ALU_DEPTH),
    .MUL_DEPTH   (MUL_DEPTH),
    .LOAD_DEPTH  (LOAD_DEPTH),
    .STORE_DEPTH (STORE_DEPTH)
  ) u_unit_credits (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_i          (issue),
    .issue_unit_i     (issue_unit),
    .unit_done_i      (unit_done_i),
    .unit_credit_ok_o (unit_credit_ok)
  );

  issue_ctrl u_issue_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .next_vid_i        (next_vid),
    .id_full_i         (id_full),
    .unit_credit_ok_i  (unit_credit_ok),
    .hazard_vd_i       (hazard_vd),
    .hazard_vs1_i      (hazard_vs1),
    .hazard_vs2_i      (hazard_vs2),
    .issue_o           (issue),
    .issue_vid_o       (issue_vid),
    .issue_unit_o      (issue_unit),
    .pe_req_o          (pe_req_o),
    .pe_req_valid_o    (pe_req_valid_o),
    .unit_resp_i       (unit_resp_i),
    .unit_resp_valid_i (unit_resp_valid_i),
    .unit_resp_ready_o (unit_resp_ready_o),
    .resp_o            (resp_o),
    .resp_valid_o      (resp_valid_o)
  );

endmodule

//--- vseq_model.svh
// Reference model of the sequencer tracking IDs, register access lists, credits and responses
`ifndef VSEQ_MODEL_SVH
`define VSEQ_MODEL_SVH

  // Model state as it stands after the last clock edge
  vid_vec_t            running;
  logic [NR_VREGS-1:0] rd_ok;
  logic [NR_VREGS-1:0] wr_ok;
  vid_t [NR_VREGS-1:0] rd_vid;
  vid_t [NR_VREGS-1:0] wr_vid;
  int unsigned         credits_used [NR_UNITS];
  // Store or scalar move waiting for its unit answer
  logic                waiting;
  op_e                 wait_op;
  // Request accepted at the last edge, due on pe_req_o now
  pe_req_t             exp_pe;
  logic                exp_valid;

  task automatic clear_model();
    running   = '0;
    rd_ok     = '0;
    wr_ok     = '0;
    rd_vid    = '0;
    wr_vid    = '0;
    waiting   = 1'b0;
    wait_op   = OP_ADD;
    exp_pe    = '0;
    exp_valid = 1'b0;
    foreach (credits_used[u]) begin
      credits_used[u] = 0;
    end
  endtask

  // First ID not in flight, scanning upwards
  function automatic vid_t lowest_free(vid_vec_t run);
    for (int i = 0; i < NR_VINSN; i++) begin
      if (!run[i]) begin
        return vid_t'(i);
      end
    end
    return '0;
  endfunction

  // Target unit per opcode, scalar moves ride on the ALU
  function automatic unit_e unit_for(op_e op);
    case (op)
      OP_MUL:   return UNIT_MUL;
      OP_LOAD:  return UNIT_LOAD;
      OP_STORE: return UNIT_STORE;
      default:  return UNIT_ALU;
    endcase
  endfunction

  // Called between edges, checks outputs and then applies the coming edge
  task automatic mirror_edge();
    vid_vec_t done;
    vid_vec_t run_d;
    vid_vec_t hvd;
    vid_vec_t hvs1;
    vid_vec_t hvs2;
    vid_vec_t row;
    unit_e    unit;
    vid_t     vid;
    logic     blocked;
    logic     can_take;
    logic     take;

    // Idle flag follows the running set after the last edge
    assert (idle_o == (running == '0))
      else report_error($sformatf("idle_o is %b, expected %b", idle_o, running == '0));

    // Issue pulse belongs to the request accepted at the last edge
    assert (pe_req_valid_o == exp_valid)
      else report_error(exp_valid ? "accepted request not issued" : "issue without acceptance");
    if (pe_req_valid_o && exp_valid) begin
      assert (pe_req_o.id == exp_pe.id)
        else report_error($sformatf("issued ID %0d, lowest free ID %0d", pe_req_o.id, exp_pe.id));
      assert (pe_req_o == exp_pe)
        else report_error($sformatf("issued request %h, expected %h", pe_req_o, exp_pe));
      // Row holds the producers still running
      row = (exp_pe.hazard_vd | exp_pe.hazard_vs1 | exp_pe.hazard_vs2) & running;
      assert (hazard_table_o[exp_pe.id] == row)
        else report_error($sformatf("table row %0d is %b, expected %b",
                                    exp_pe.id, hazard_table_o[exp_pe.id], row));
    end
    exp_valid = 1'b0;

    // Completions end their instruction at the coming edge
    done = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_done_i[u].valid) begin
        done[unit_done_i[u].vid] = 1'b1;
      end
    end
    run_d = running & ~done;
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_ok[v] = rd_ok[v] && run_d[rd_vid[v]];
      wr_ok[v] = wr_ok[v] && run_d[wr_vid[v]];
    end

    // RAW per source, WAR onto both sources, WAW onto vd
    hvd  = '0;
    hvs1 = '0;
    hvs2 = '0;
    if (req_i.use_vs1 && wr_ok[req_i.vs1]) begin
      hvs1[wr_vid[req_i.vs1]] = 1'b1;
    end
    if (req_i.use_vs2 && wr_ok[req_i.vs2]) begin
      hvs2[wr_vid[req_i.vs2]] = 1'b1;
    end
    if (req_i.use_vd && rd_ok[req_i.vd]) begin
      hvs1[rd_vid[req_i.vd]] = 1'b1;
      hvs2[rd_vid[req_i.vd]] = 1'b1;
    end
    if (req_i.use_vd && wr_ok[req_i.vd]) begin
      hvd[wr_vid[req_i.vd]] = 1'b1;
    end

    // Acceptance rule
    unit     = unit_for(req_i.op);
    vid      = lowest_free(running);
    blocked  = !(req_i.use_vs1 || req_i.use_vs2) && ((hvd | hvs1 | hvs2) != '0);
    can_take = !waiting && !(&running) && (credits_used[unit] < DEPTH[unit]) && !blocked;
    assert (req_ready_o == can_take)
      else report_error($sformatf("req_ready_o is %b, expected %b", req_ready_o, can_take));
    take = req_valid_i && req_ready_o;
    if (take) begin
      assert (!waiting)
        else report_error("request accepted while a response is pending");
      assert (credits_used[unit] < DEPTH[unit])
        else report_error($sformatf("issue to unit %0d with no credit left", unit));
      assert (!blocked)
        else report_error("instruction without vector operands accepted with hazards");
    end

    // Unit answer goes straight back to the dispatcher
    if (unit_resp_valid_i) begin
      assert (waiting && unit_resp_ready_o && resp_valid_o)
        else report_error("unit answer not passed on as a response");
      assert (resp_o.op == wait_op && resp_o.word == unit_resp_i)
        else report_error($sformatf("response op %0d word %h, expected op %0d word %h",
                                    resp_o.op, resp_o.word, wait_op, unit_resp_i));
      waiting = 1'b0;
    end else begin
      assert (!resp_valid_o && !unit_resp_ready_o)
        else report_error("response without a unit answer");
    end

    // State after the coming edge
    if (take) begin
      exp_pe = '{req: req_i, id: vid, unit: unit,
                 hazard_vd: hvd, hazard_vs1: hvs1, hazard_vs2: hvs2};
      exp_valid = 1'b1;
      if (req_i.op == OP_STORE || req_i.op == OP_MVXS) begin
        waiting = 1'b1;
        wait_op = req_i.op;
      end
      if (req_i.use_vd) begin
        wr_ok[req_i.vd]  = 1'b1;
        wr_vid[req_i.vd] = vid;
      end
      if (req_i.use_vs1) begin
        rd_ok[req_i.vs1]  = 1'b1;
        rd_vid[req_i.vs1] = vid;
      end
      if (req_i.use_vs2) begin
        rd_ok[req_i.vs2]  = 1'b1;
        rd_vid[req_i.vs2] = vid;
      end
      credits_used[unit]++;
    end
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_done_i[u].valid) begin
        credits_used[u]--;
      end
    end
    running = run_d;
    if (take) begin
      running[vid] = 1'b1;
    end
  endtask

`endif

//--- vseq_tb.sv
// Testbench for the vector sequencer, random dispatcher and unit traffic checked against a model
`timescale 1ns/100ps

module vseq_tb;

  import vseq_cfg_pkg::*;
  import vseq_req_pkg::*;

  localparam int unsigned ALU_DEPTH   = 2;
  localparam int unsigned MUL_DEPTH   = 2;
  localparam int unsigned LOAD_DEPTH  = 4;
  localparam int unsigned STORE_DEPTH = 4;
  localparam int unsigned DEPTH [NR_UNITS] = '{ALU_DEPTH, MUL_DEPTH, LOAD_DEPTH, STORE_DEPTH};
  localparam int unsigned NR_REQS = 400;
  // 40 cycles per request is far above the worst stall
  localparam int unsigned TIMEOUT_CYCLES = NR_REQS * 40;
  localparam logic [31:0] SEED = 32'h42ac4aa7;

  // Instruction waiting in a unit queue
  typedef struct packed {
    logic        resp;
    op_e         op;
    vid_t        vid;
    logic [31:0] due;
  } pend_t;

  logic                              clk_i;
  logic                              rst_ni;
  seq_req_t                          req_i;
  logic                              req_valid_i;
  logic                              req_ready_o;
  pe_req_t                           pe_req_o;
  logic                              pe_req_valid_o;
  unit_done_t [NR_UNITS-1:0]         unit_done_i = '0;
  resp_word_u                        unit_resp_i = '0;
  logic                              unit_resp_valid_i = 1'b0;
  logic                              unit_resp_ready_o;
  seq_resp_t                         resp_o;
  logic                              resp_valid_o;
  vid_vec_t [NR_VINSN-1:0]           hazard_table_o;
  logic                              idle_o;

  int unsigned error_cnt  = 0;
  int unsigned issued_cnt = 0;
  int unsigned cycle      = 0;
  logic        model_on   = 1'b0;
  // In-order completion queues, one per unit
  pend_t       pend_q [NR_UNITS][$];

  vseq_top #(
    .ALU_DEPTH   (ALU_DEPTH),
    .MUL_DEPTH   (MUL_DEPTH),
    .LOAD_DEPTH  (LOAD_DEPTH),
    .STORE_DEPTH (STORE_DEPTH)
  ) u_vseq_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .pe_req_o          (pe_req_o),
    .pe_req_valid_o    (pe_req_valid_o),
    .unit_done_i       (unit_done_i),
    .unit_resp_i       (unit_resp_i),
    .unit_resp_valid_i (unit_resp_valid_i),
    .unit_resp_ready_o (unit_resp_ready_o),
    .resp_o            (resp_o),
    .resp_valid_o      (resp_valid_o),
    .hazard_table_o    (hazard_table_o),
    .idle_o            (idle_o)
  );

  task automatic report_error(string msg);
    error_cnt++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  `include "vseq_model.svh"

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Eight registers only, so hazards show up often
  function automatic seq_req_t random_req();
    seq_req_t r;
    r     = '0;
    r.op  = op_e'($urandom_range(0, 4));
    r.vd  = vreg_t'($urandom_range(0, 7));
    r.vs1 = vreg_t'($urandom_range(0, 7));
    r.vs2 = vreg_t'($urandom_range(0, 7));
    r.vl  = 16'($urandom_range(1, 256));
    case (r.op)
      OP_LOAD: begin
        r.use_vd = 1'b1;
      end
      OP_STORE: begin
        r.use_vs1 = 1'b1;
        r.use_vs2 = 1'($urandom_range(0, 1));
      end
      OP_MVXS: begin
        r.use_vs2 = 1'b1;
      end
      default: begin
        // Some arithmetic ops without sources, these must wait for hazards
        r.use_vd  = 1'b1;
        r.use_vs1 = 1'($urandom_range(0, 1));
        r.use_vs2 = 1'($urandom_range(0, 1));
      end
    endcase
    return r;
  endfunction

  function automatic resp_word_u answer_word(op_e op);
    resp_word_u w;
    w = '0;
    if (op == OP_STORE) begin
      w.store_status.fault        = 1'($urandom_range(0, 1));
      w.store_status.fault_vstart = 16'($urandom);
    end else begin
      w.scalar_data = $urandom;
    end
    return w;
  endfunction

  // Quiet state after reset and after drain
  task automatic check_quiet(string when);
    assert (idle_o) else report_error($sformatf("idle_o low %s", when));
    assert (req_ready_o && !pe_req_valid_o && !resp_valid_o && !unit_resp_ready_o)
      else report_error($sformatf("handshake outputs not at rest %s", when));
    for (int i = 0; i < NR_VINSN; i++) begin
      assert (hazard_table_o[i] == '0)
        else report_error($sformatf("table row %0d is %b %s", i, hazard_table_o[i], when));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, monitor, units and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin : monitor
    pend_t entry;
    if (model_on) begin
      mirror_edge();
      if (pe_req_valid_o) begin
        issued_cnt++;
        entry.resp = (pe_req_o.req.op == OP_STORE) || (pe_req_o.req.op == OP_MVXS);
        entry.op   = pe_req_o.req.op;
        entry.vid  = pe_req_o.id;
        entry.due  = cycle + $urandom_range(1, 12);
        pend_q[pe_req_o.unit].push_back(entry);
      end
    end
  end

  // Units finish in order, at most one per cycle each
  always @(posedge clk_i) begin : unit_model
    unit_resp_valid_i <= 1'b0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (pend_q[u].size() != 0 && pend_q[u][0].due <= cycle) begin
        unit_done_i[u] <= '{valid: 1'b1, vid: pend_q[u][0].vid};
        if (pend_q[u][0].resp) begin
          unit_resp_i       <= answer_word(pend_q[u][0].op);
          unit_resp_valid_i <= 1'b1;
        end
        void'(pend_q[u].pop_front());
      end else begin
        unit_done_i[u] <= '0;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the traffic did not drain", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Dispatcher
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned gap;
    void'($urandom(SEED));
    rst_ni      <= 1'b0;
    req_i       <= '0;
    req_valid_i <= 1'b0;
    clear_model();
    repeat (3) @(posedge clk_i);
    rst_ni   <= 1'b1;
    model_on = 1'b1;
    @(negedge clk_i);
    check_quiet("after reset");
    @(posedge clk_i);
    for (int n = 0; n < NR_REQS; n++) begin
      gap = $urandom_range(0, 3);
      if (gap != 0) begin
        req_valid_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
      req_i       <= random_req();
      req_valid_i <= 1'b1;
      // Held until ready is seen, the handshake is the next edge
      @(negedge clk_i);
      while (!req_ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    while (!idle_o) begin
      @(negedge clk_i);
    end
    check_quiet("after drain");
    $display("Requests issued: %0d, errors: %0d", issued_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vseq.f
+incdir+.
vseq_cfg_pkg.sv
vseq_req_pkg.sv
vinsn_tracker.sv
vreg_access_lists.sv
hazard_table.sv
unit_credits.sv
issue_ctrl.sv
vseq_top.sv
vseq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the vector sequencer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
  -f vseq.f --top-module vseq_tb --Mdir "$BUILD" -o vseq_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/vseq_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
exit 1
